/* pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Datapath and tag widths
`define PIPE_TAG_W    3
`define PIPE_DATA_W   8

// Wait counters saturate at their all-ones value
`define PIPE_WAIT_W   4
`define PIPE_STAMP_W  16
`define PIPE_NUM_TAGS 8

// Configuration word bit positions
`define PIPE_CFG_SAT_BIT   0
`define PIPE_CFG_TRACE_BIT 1

`endif

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // Where an instruction sits, as the tracer sees it
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        EMPTY
    } stage_t;

    // PASS forwards operand a unchanged
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_XOR  = 2'd2,
        OP_PASS = 2'd3
    } op_t;

endpackage

`default_nettype wire

/* pipe_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module pipe_cfg_regs (
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_wr,
    input  logic [1:0] cfg_wdata,
    output logic [1:0] cfg_rdata,
    output logic       sat_en,
    output logic       trace_en
);

    logic [1:0] cfg_q;

    // Single configuration word, written on the strobe edge
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= 2'b00;
        end else if (cfg_wr) begin
            cfg_q <= cfg_wdata;
        end
    end

    // Readback straight from the register
    assign cfg_rdata = cfg_q;

    // Mode bits for the ALU and the tracer
    assign sat_en   = cfg_q[`PIPE_CFG_SAT_BIT];
    assign trace_en = cfg_q[`PIPE_CFG_TRACE_BIT];

    // A write must carry a known word, or both neighbors go undefined
    a_cfg_wdata_known: assert property (
        @(posedge clk) disable iff (rst)
        cfg_wr |-> !$isunknown(cfg_wdata)
    ) else $error("config write with unknown data %b", cfg_wdata);

endmodule

`default_nettype wire

/* pipe_stage_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module pipe_stage_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    issue,
    input  logic [`PIPE_TAG_W-1:0]  issue_tag,
    input  pipe_pkg::op_t           issue_op,
    input  logic [`PIPE_DATA_W-1:0] issue_a,
    input  logic [`PIPE_DATA_W-1:0] issue_b,
    output logic                    f_valid,
    output logic [`PIPE_TAG_W-1:0]  f_tag,
    output logic                    d_valid,
    output logic [`PIPE_TAG_W-1:0]  d_tag,
    output logic                    w_valid,
    output logic [`PIPE_TAG_W-1:0]  w_tag,
    output logic                    e_valid,
    output pipe_pkg::op_t           e_op,
    output logic [`PIPE_DATA_W-1:0] e_a,
    output logic [`PIPE_DATA_W-1:0] e_b
);

    pipe_pkg::op_t           f_op;
    pipe_pkg::op_t           d_op;
    logic [`PIPE_DATA_W-1:0] f_a;
    logic [`PIPE_DATA_W-1:0] f_b;
    logic [`PIPE_DATA_W-1:0] d_a;
    logic [`PIPE_DATA_W-1:0] d_b;
    logic [`PIPE_TAG_W-1:0]  e_tag;
    logic                    m_valid;
    logic [`PIPE_TAG_W-1:0]  m_tag;

    // Valid bits, F and D freeze on stall while E takes a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            f_valid <= 1'b0;
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            m_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            if (stall) begin
                e_valid <= 1'b0;
            end else begin
                f_valid <= issue;
                d_valid <= f_valid;
                e_valid <= d_valid;
            end
            m_valid <= e_valid;
            w_valid <= m_valid;
        end
    end

    // Stage payload follows the same hold rule
    always_ff @(posedge clk) begin
        if (!stall) begin
            f_tag <= issue_tag;
            f_op  <= issue_op;
            f_a   <= issue_a;
            f_b   <= issue_b;
            d_tag <= f_tag;
            d_op  <= f_op;
            d_a   <= f_a;
            d_b   <= f_b;
            e_tag <= d_tag;
            e_op  <= d_op;
            e_a   <= d_a;
            e_b   <= d_b;
        end
        m_tag <= e_tag;
        w_tag <= m_tag;
    end

    // Issue only lands when the front of the pipe is moving
    a_no_issue_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        issue |-> !stall
    ) else $error("issue of tag %0d while stalled", issue_tag);

    // A new tag must not match any instruction still in the pipe
    a_issue_tag_unused: assert property (
        @(posedge clk) disable iff (rst)
        issue |-> !((f_valid && f_tag == issue_tag) ||
                    (d_valid && d_tag == issue_tag) ||
                    (e_valid && e_tag == issue_tag) ||
                    (m_valid && m_tag == issue_tag) ||
                    (w_valid && w_tag == issue_tag))
    ) else $error("issue of tag %0d already in flight", issue_tag);

endmodule

`default_nettype wire

/* pipe_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module pipe_alu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    e_valid,
    input  pipe_pkg::op_t           e_op,
    input  logic [`PIPE_DATA_W-1:0] e_a,
    input  logic [`PIPE_DATA_W-1:0] e_b,
    input  logic                    sat_en,
    output logic [`PIPE_DATA_W-1:0] w_result
);

    logic [`PIPE_DATA_W:0]   sum_ext;
    logic [`PIPE_DATA_W:0]   diff_ext;
    logic [`PIPE_DATA_W-1:0] e_result;
    logic [`PIPE_DATA_W-1:0] m_result;
    logic                    m_valid;

    // Extra top bit is the carry on add and the borrow on sub
    assign sum_ext  = {1'b0, e_a} + {1'b0, e_b};
    assign diff_ext = {1'b0, e_a} - {1'b0, e_b};

    always_comb begin
        case (e_op)
            pipe_pkg::OP_ADD: begin
                e_result = (sat_en && sum_ext[`PIPE_DATA_W]) ?
                           {`PIPE_DATA_W{1'b1}} : sum_ext[`PIPE_DATA_W-1:0];
            end
            pipe_pkg::OP_SUB: begin
                e_result = (sat_en && diff_ext[`PIPE_DATA_W]) ?
                           {`PIPE_DATA_W{1'b0}} : diff_ext[`PIPE_DATA_W-1:0];
            end
            pipe_pkg::OP_XOR: e_result = e_a ^ e_b;
            default:          e_result = e_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= e_valid;
        end
    end

    // Result rides along through M into W, only real instructions load it
    always_ff @(posedge clk) begin
        if (e_valid) begin
            m_result <= e_result;
        end
        if (m_valid) begin
            w_result <= m_result;
        end
    end

endmodule

`default_nettype wire

/* pipe_trace.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module pipe_trace (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     trace_en,
    input  logic                     issue,
    input  logic [`PIPE_TAG_W-1:0]   issue_tag,
    input  logic                     f_valid,
    input  logic [`PIPE_TAG_W-1:0]   f_tag,
    input  logic                     d_valid,
    input  logic [`PIPE_TAG_W-1:0]   d_tag,
    input  logic                     w_valid,
    input  logic [`PIPE_TAG_W-1:0]   w_tag,
    input  logic [`PIPE_DATA_W-1:0]  w_result,
    output logic                     retire,
    output logic [`PIPE_TAG_W-1:0]   retire_tag,
    output logic [`PIPE_DATA_W-1:0]  retire_result,
    output logic [`PIPE_WAIT_W-1:0]  retire_fetch_wait,
    output logic [`PIPE_WAIT_W-1:0]  retire_decode_wait,
    output logic [`PIPE_STAMP_W-1:0] retire_stamp
);

    localparam logic [`PIPE_WAIT_W-1:0] WAIT_MAX = {`PIPE_WAIT_W{1'b1}};

    // Per-tag position, EXECUTE stands for anywhere from E through W
    pipe_pkg::stage_t        tag_state [`PIPE_NUM_TAGS];
    logic [`PIPE_WAIT_W-1:0] fetch_wait [`PIPE_NUM_TAGS];
    logic [`PIPE_WAIT_W-1:0] decode_wait [`PIPE_NUM_TAGS];
    logic [`PIPE_STAMP_W-1:0] stamp;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_NUM_TAGS; i++) begin
                tag_state[i] <= pipe_pkg::EMPTY;
            end
        end else begin
            for (int i = 0; i < `PIPE_NUM_TAGS; i++) begin
                if (w_valid && w_tag == i) begin
                    tag_state[i] <= pipe_pkg::EMPTY;
                end
                if (!stall && d_valid && d_tag == i) begin
                    tag_state[i] <= pipe_pkg::EXECUTE;
                end
                if (!stall && f_valid && f_tag == i) begin
                    tag_state[i] <= pipe_pkg::DECODE;
                end
                if (issue && issue_tag == i) begin
                    tag_state[i] <= pipe_pkg::FETCH;
                end
            end
        end
    end

    // Wait counters, cleared on issue and bumped on each stalled edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < `PIPE_NUM_TAGS; i++) begin
            if (issue && issue_tag == i) begin
                fetch_wait[i]  <= '0;
                decode_wait[i] <= '0;
            end else if (stall) begin
                if (f_valid && f_tag == i && fetch_wait[i] != WAIT_MAX) begin
                    fetch_wait[i] <= fetch_wait[i] + 1'b1;
                end
                if (d_valid && d_tag == i && decode_wait[i] != WAIT_MAX) begin
                    decode_wait[i] <= decode_wait[i] + 1'b1;
                end
            end
        end
    end

    // Free-running cycle stamp
    always_ff @(posedge clk) begin
        if (rst) begin
            stamp <= '0;
        end else begin
            stamp <= stamp + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= 1'b0;
        end else begin
            retire <= w_valid;
        end
    end

    // Record for the instruction now in W
    always_ff @(posedge clk) begin
        if (w_valid) begin
            retire_tag         <= w_tag;
            retire_result      <= w_result;
            retire_fetch_wait  <= trace_en ? fetch_wait[w_tag] : '0;
            retire_decode_wait <= trace_en ? decode_wait[w_tag] : '0;
            retire_stamp       <= stamp;
        end
    end

    a_issue_tag_free: assert property (
        @(posedge clk) disable iff (rst)
        issue |-> tag_state[issue_tag] == pipe_pkg::EMPTY
    ) else $error("tag %0d issued while still in %s",
                  issue_tag, tag_state[issue_tag].name());

endmodule

`default_nettype wire

/* pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module pipe_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic [`PIPE_TAG_W-1:0]   issue_tag,
    input  pipe_pkg::op_t            issue_op,
    input  logic [`PIPE_DATA_W-1:0]  issue_a,
    input  logic [`PIPE_DATA_W-1:0]  issue_b,
    input  logic                     stall,
    input  logic                     cfg_wr,
    input  logic [1:0]               cfg_wdata,
    output logic [1:0]               cfg_rdata,
    output logic                     retire,
    output logic [`PIPE_TAG_W-1:0]   retire_tag,
    output logic [`PIPE_DATA_W-1:0]  retire_result,
    output logic [`PIPE_WAIT_W-1:0]  retire_fetch_wait,
    output logic [`PIPE_WAIT_W-1:0]  retire_decode_wait,
    output logic [`PIPE_STAMP_W-1:0] retire_stamp
);

    logic                    sat_en;
    logic                    trace_en;
    logic                    f_valid;
    logic [`PIPE_TAG_W-1:0]  f_tag;
    logic                    d_valid;
    logic [`PIPE_TAG_W-1:0]  d_tag;
    logic                    e_valid;
    pipe_pkg::op_t           e_op;
    logic [`PIPE_DATA_W-1:0] e_a;
    logic [`PIPE_DATA_W-1:0] e_b;
    logic                    w_valid;
    logic [`PIPE_TAG_W-1:0]  w_tag;
    logic [`PIPE_DATA_W-1:0] w_result;

    pipe_cfg_regs u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .sat_en    (sat_en),
        .trace_en  (trace_en)
    );

    pipe_stage_ctrl u_stages (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .issue     (issue),
        .issue_tag (issue_tag),
        .issue_op  (issue_op),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .f_valid   (f_valid),
        .f_tag     (f_tag),
        .d_valid   (d_valid),
        .d_tag     (d_tag),
        .w_valid   (w_valid),
        .w_tag     (w_tag),
        .e_valid   (e_valid),
        .e_op      (e_op),
        .e_a       (e_a),
        .e_b       (e_b)
    );

    pipe_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .e_valid  (e_valid),
        .e_op     (e_op),
        .e_a      (e_a),
        .e_b      (e_b),
        .sat_en   (sat_en),
        .w_result (w_result)
    );

    pipe_trace u_trace (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .trace_en           (trace_en),
        .issue              (issue),
        .issue_tag          (issue_tag),
        .f_valid            (f_valid),
        .f_tag              (f_tag),
        .d_valid            (d_valid),
        .d_tag              (d_tag),
        .w_valid            (w_valid),
        .w_tag              (w_tag),
        .w_result           (w_result),
        .retire             (retire),
        .retire_tag         (retire_tag),
        .retire_result      (retire_result),
        .retire_fetch_wait  (retire_fetch_wait),
        .retire_decode_wait (retire_decode_wait),
        .retire_stamp       (retire_stamp)
    );

endmodule

`default_nettype wire

/* pipe_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module pipe_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic [`PIPE_TAG_W-1:0]   issue_tag,
    input  logic [`PIPE_DATA_W-1:0]  issue_exp,
    input  logic                     stall,
    input  logic                     cfg_wr,
    input  logic [1:0]               cfg_wdata,
    input  logic [1:0]               cfg_rdata,
    input  logic                     retire,
    input  logic [`PIPE_TAG_W-1:0]   retire_tag,
    input  logic [`PIPE_DATA_W-1:0]  retire_result,
    input  logic [`PIPE_WAIT_W-1:0]  retire_fetch_wait,
    input  logic [`PIPE_WAIT_W-1:0]  retire_decode_wait,
    input  logic [`PIPE_STAMP_W-1:0] retire_stamp,
    output logic                     busy,
    output int                       error_count,
    output int                       check_count
);

    localparam int STAGES   = 5;
    localparam int WAIT_MAX = (1 << `PIPE_WAIT_W) - 1;

    // Slots 0 to 4 stand for F, D, E, M and W
    logic                    slot_valid [STAGES];
    logic [`PIPE_TAG_W-1:0]  slot_tag [STAGES];
    logic [`PIPE_DATA_W-1:0] exp_result [`PIPE_NUM_TAGS];
    int                      fetch_stalls [`PIPE_NUM_TAGS];
    int                      decode_stalls [`PIPE_NUM_TAGS];
    int                      issue_stamp [`PIPE_NUM_TAGS];
    logic [1:0]              cfg_word;
    int                      cycle;
    bit                      reset_seen;

    // Record due on the retire outputs after the current edge
    bit                      rec_valid;
    int                      rec_tag;
    int                      rec_result;
    int                      rec_fetch;
    int                      rec_decode;
    int                      rec_stamp;

    initial begin
        error_count = 0;
        check_count = 0;
        busy        = 1'b0;
        reset_seen  = 1'b0;
        rec_valid   = 1'b0;
    end

    function automatic int clamp_wait(input int n);
        return (n > WAIT_MAX) ? WAIT_MAX : n;
    endfunction

    task automatic compare_field(input string field, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %0t: tag %0d %s got %0d expected %0d",
                     $time, rec_tag, field, got, expected);
            error_count++;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < STAGES; i++) begin
            slot_valid[i] = 1'b0;
        end
        cfg_word  = 2'b00;
        rec_valid = 1'b0;
        cycle     = 0;
    endtask

    task automatic advance_model();
        int t;
        rec_valid = 1'b0;
        // Instruction in W now produces the record for the next edge
        if (slot_valid[4]) begin
            t          = slot_tag[4];
            rec_valid  = 1'b1;
            rec_tag    = t;
            rec_result = exp_result[t];
            rec_fetch  = cfg_word[`PIPE_CFG_TRACE_BIT] ? clamp_wait(fetch_stalls[t]) : 0;
            rec_decode = cfg_word[`PIPE_CFG_TRACE_BIT] ? clamp_wait(decode_stalls[t]) : 0;
            // Five clocks of latency plus one per stalled edge in F or D
            rec_stamp  = (issue_stamp[t] + 5 + fetch_stalls[t] + decode_stalls[t]) & 16'hffff;
        end
        if (stall) begin
            if (slot_valid[0]) fetch_stalls[slot_tag[0]]++;
            if (slot_valid[1]) decode_stalls[slot_tag[1]]++;
        end
        for (int i = STAGES - 1; i > 0; i--) begin
            if (!stall || i > 2) begin
                slot_valid[i] = slot_valid[i-1];
                slot_tag[i]   = slot_tag[i-1];
            end
        end
        if (stall) begin
            slot_valid[2] = 1'b0;
        end else begin
            slot_valid[0] = issue;
            slot_tag[0]   = issue_tag;
            if (issue) begin
                exp_result[issue_tag]    = issue_exp;
                fetch_stalls[issue_tag]  = 0;
                decode_stalls[issue_tag] = 0;
                issue_stamp[issue_tag]   = cycle;
            end
        end
        if (cfg_wr) cfg_word = cfg_wdata;
        cycle++;
    endtask

    function automatic logic in_flight();
        logic any;
        any = rec_valid;
        for (int i = 0; i < STAGES; i++) begin
            any = any | slot_valid[i];
        end
        return any;
    endfunction

    always @(posedge clk) begin
        if (reset_seen) begin
            if (cfg_rdata !== cfg_word) begin
                $display("CHECK FAILED %0t: cfg_rdata got %b expected %b",
                         $time, cfg_rdata, cfg_word);
                error_count++;
            end
            if (rec_valid) begin
                if (retire !== 1'b1) begin
                    $display("Retire record for tag %0d did not arrive at %0t", rec_tag, $time);
                    error_count++;
                end else begin
                    check_count++;
                    compare_field("tag", retire_tag, rec_tag);
                    compare_field("result", retire_result, rec_result);
                    compare_field("fetch_wait", retire_fetch_wait, rec_fetch);
                    compare_field("decode_wait", retire_decode_wait, rec_decode);
                    compare_field("stamp", retire_stamp, rec_stamp);
                end
            end else if (retire !== 1'b0) begin
                $display("Unexpected retire of tag %0d at %0t", retire_tag, $time);
                error_count++;
            end
        end
        if (rst) begin
            clear_model();
            reset_seen = 1'b1;
        end else begin
            advance_model();
        end
        busy <= in_flight();
    end

endmodule

`default_nettype wire

/* tb_pipe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_consts.svh"

module tb_pipe;

    localparam STIM_FILE        = "pipe_stimulus.txt";
    localparam int MAX_LINES    = 256;
    localparam int DRAIN_CYCLES = 20;

    logic                     clk;
    logic                     rst;
    logic                     issue;
    logic [`PIPE_TAG_W-1:0]   issue_tag;
    pipe_pkg::op_t            issue_op;
    logic [`PIPE_DATA_W-1:0]  issue_a;
    logic [`PIPE_DATA_W-1:0]  issue_b;
    logic [`PIPE_DATA_W-1:0]  issue_exp;
    logic                     stall;
    logic                     cfg_wr;
    logic [1:0]               cfg_wdata;
    logic [1:0]               cfg_rdata;
    logic                     retire;
    logic [`PIPE_TAG_W-1:0]   retire_tag;
    logic [`PIPE_DATA_W-1:0]  retire_result;
    logic [`PIPE_WAIT_W-1:0]  retire_fetch_wait;
    logic [`PIPE_WAIT_W-1:0]  retire_decode_wait;
    logic [`PIPE_STAMP_W-1:0] retire_stamp;
    logic                     busy;
    int                       error_count;
    int                       check_count;

    byte line_kind [MAX_LINES];
    int  line_arg [MAX_LINES][5];
    int  line_count;
    int  bad_lines   = 0;
    int  cycle_limit = 0;
    int  cycles;

    pipe_top uut (
        .clk                (clk),
        .rst                (rst),
        .issue              (issue),
        .issue_tag          (issue_tag),
        .issue_op           (issue_op),
        .issue_a            (issue_a),
        .issue_b            (issue_b),
        .stall              (stall),
        .cfg_wr             (cfg_wr),
        .cfg_wdata          (cfg_wdata),
        .cfg_rdata          (cfg_rdata),
        .retire             (retire),
        .retire_tag         (retire_tag),
        .retire_result      (retire_result),
        .retire_fetch_wait  (retire_fetch_wait),
        .retire_decode_wait (retire_decode_wait),
        .retire_stamp       (retire_stamp)
    );

    pipe_checker chk (
        .clk                (clk),
        .rst                (rst),
        .issue              (issue),
        .issue_tag          (issue_tag),
        .issue_exp          (issue_exp),
        .stall              (stall),
        .cfg_wr             (cfg_wr),
        .cfg_wdata          (cfg_wdata),
        .cfg_rdata          (cfg_rdata),
        .retire             (retire),
        .retire_tag         (retire_tag),
        .retire_result      (retire_result),
        .retire_fetch_wait  (retire_fetch_wait),
        .retire_decode_wait (retire_decode_wait),
        .retire_stamp       (retire_stamp),
        .busy               (busy),
        .error_count        (error_count),
        .check_count        (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Lines starting with # are skipped up to the end of the line
    task automatic read_stimulus(output bit ok);
        int  fd;
        int  r;
        int  c;
        byte kind;
        int  v [5];
        ok         = 1'b0;
        line_count = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            r  = $fscanf(fd, " %c", kind);
            while (r == 1) begin
                if (kind == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) c = $fgetc(fd);
                end else begin
                    v = '{0, 0, 0, 0, 0};
                    if (kind == "I") r = $fscanf(fd, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
                    else r = $fscanf(fd, "%d", v[0]);
                    if (line_count < MAX_LINES) begin
                        line_kind[line_count] = kind;
                        line_arg[line_count]  = v;
                        line_count++;
                    end else begin
                        $display("Stimulus file has more than %0d lines", MAX_LINES);
                        bad_lines++;
                    end
                end
                r = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    function automatic int count_cycles();
        int total = 0;
        for (int i = 0; i < line_count; i++) begin
            if (line_kind[i] == "I" || line_kind[i] == "C") total += 1;
            else total += line_arg[i][0];
        end
        return total;
    endfunction

    // Inputs change 1 ns after the rising edge, strobes default low
    task automatic next_cycle();
        @(posedge clk);
        #1;
        rst    = 1'b0;
        issue  = 1'b0;
        stall  = 1'b0;
        cfg_wr = 1'b0;
    endtask

    task automatic apply_line(input int i);
        case (line_kind[i])
            "I": begin
                next_cycle();
                issue     = 1'b1;
                issue_tag = line_arg[i][0][`PIPE_TAG_W-1:0];
                issue_op  = pipe_pkg::op_t'(line_arg[i][1][1:0]);
                issue_a   = line_arg[i][2][`PIPE_DATA_W-1:0];
                issue_b   = line_arg[i][3][`PIPE_DATA_W-1:0];
                issue_exp = line_arg[i][4][`PIPE_DATA_W-1:0];
            end
            "C": begin
                next_cycle();
                cfg_wr    = 1'b1;
                cfg_wdata = line_arg[i][0][1:0];
            end
            "S": repeat (line_arg[i][0]) begin
                next_cycle();
                stall = 1'b1;
            end
            "N": repeat (line_arg[i][0]) next_cycle();
            "R": repeat (line_arg[i][0]) begin
                next_cycle();
                rst = 1'b1;
            end
            default: begin
                $display("Unknown stimulus line kind '%c'", line_kind[i]);
                bad_lines++;
            end
        endcase
    endtask

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: retire records still missing after %0d cycles", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        bit ok;
        rst       = 1'b1;
        issue     = 1'b0;
        issue_tag = '0;
        issue_op  = pipe_pkg::OP_ADD;
        issue_a   = '0;
        issue_b   = '0;
        issue_exp = '0;
        stall     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_wdata = 2'b00;
        read_stimulus(ok);
        if (!ok) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            cycle_limit = 2 * (count_cycles() + 3 + DRAIN_CYCLES);
            repeat (3) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int i = 0; i < line_count; i++) begin
                apply_line(i);
            end
            next_cycle();
            while (busy) next_cycle();
            repeat (3) next_cycle();
            $display("retires checked: %0d, errors: %0d", check_count, error_count + bad_lines);
            if (error_count == 0 && bad_lines == 0 && check_count > 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* pipe_stimulus.txt */
# C word | I tag op a b expected | S stall cycles | N idle cycles | R reset cycles
# Opcodes 0 add, 1 sub, 2 xor, 3 pass; all numbers decimal
I 0 0 200 100 44
N 6
I 1 1 5 10 251
N 6
I 2 2 170 85 255
N 6
I 3 3 77 9 77
N 6
# Five in flight back to back
I 4 0 1 2 3
I 5 1 9 4 5
I 6 2 15 240 255
I 7 3 33 0 33
I 0 0 100 27 127
N 8
# Trace on, stalls with F and D occupied
C 2
I 1 0 10 20 30
I 2 1 50 8 42
S 3
I 3 2 1 3 2
S 2
N 8
# Trace off, wait fields read zero
C 0
I 4 0 3 4 7
I 5 1 9 9 0
S 4
N 8
# Saturation on
C 1
I 6 0 200 100 255
I 7 1 5 10 0
I 0 0 100 50 150
N 8
# Saturation and trace, long stall saturates the wait counters
C 3
I 1 0 250 10 255
I 2 2 6 3 5
S 17
N 8
# Reset with two instructions in flight, then wrapping sub again
I 3 0 1 1 2
I 4 0 2 2 4
R 2
N 8
I 3 1 0 1 255
N 8

/* sim.f */
+incdir+.
pipe_pkg.sv
pipe_cfg_regs.sv
pipe_stage_ctrl.sv
pipe_alu.sv
pipe_trace.sv
pipe_top.sv
pipe_checker.sv
tb_pipe.sv
